/* bench/vita_conv_tb.sv */
/*
 directed testbench for the 16-to-8 bit VITA packet converter
 packets are built here, loaded through the host port, converted,
 read back and compared word by word with a reference model
 random samples come from a 32-bit Galois LFSR with a fixed seed
*/
`timescale 1ns/1ps
`include "vita_conv_consts.svh"

module vita_conv_tb;

   // 9 packets of 68 words in all; each word costs at most 5 cycles
   localparam int total_words    = 68;
   localparam int packet_count   = 9;
   localparam int worst_cycles   = 5 * total_words + 20 * packet_count;
   localparam int timeout_cycles = 2 * worst_cycles + 8;

   logic                      clk;
   logic                      arst_n_i;
   logic                      set_stb_i;
   logic [7:0]                set_addr_i;
   logic [31:0]               set_data_i;
   logic                      start_i;
   logic [`VC_ADDR_W-1:0]     pkt_len_i;
   logic                      done_o;
   logic                      host_en_i;
   logic                      host_we_i;
   logic [`VC_ADDR_W-1:0]     host_adr_i;
   vita_conv_pkg::buf_word_t  host_dat_i;
   vita_conv_pkg::buf_word_t  host_dat_o;

   vita_conv_pkg::buf_word_t  in_img [64];
   vita_conv_pkg::buf_word_t  exp_img [64];
   vita_conv_pkg::conv_cfg_t  model_cfg;
   logic [31:0]               lfsr;
   int                        in_len;
   int                        cycle_cnt;

   vita_conv_top dut0 (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .start_i    (start_i),
      .pkt_len_i  (pkt_len_i),
      .done_o     (done_o),
      .host_en_i  (host_en_i),
      .host_we_i  (host_we_i),
      .host_adr_i (host_adr_i),
      .host_dat_i (host_dat_i),
      .host_dat_o (host_dat_o)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #50 clk = ~clk;
   end

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < timeout_cycles)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
      $display("Simulation failed");
      $fatal(1);
   end

   // galois form, taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] rand_bits(input int nbits);
      logic [31:0] r;
      r = '0;
      for (int b = 0; b < nbits; b++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic check_word(input vita_conv_pkg::buf_word_t got,
                             input vita_conv_pkg::buf_word_t exp, input string what);
      if (got !== exp)
      begin
         $display("error: %0t ns: %s read %h, expected %h", $time, what, got, exp);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic check_done(input logic exp, input string what);
      if (done_o !== exp)
      begin
         $display("error: %0t ns: %s done_o is %b, expected %b", $time, what, done_o, exp);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   function automatic int header_words(input logic [31:0] h);
      int n;
      n = 1;
      if (h[28])
         n += 1;
      if (h[27])
         n += 2;
      if (h[23:22] != 2'b00)
         n += 1;
      if (h[21:20] != 2'b00)
         n += 2;
      return n;
   endfunction

   // scale, shift by 10, clip to 16 bits, round half away from zero, clip to 8 bits
   function automatic logic signed [7:0] convert_component(input logic signed [15:0] s,
                                                           input logic signed [17:0] k);
      longint v;
      longint r;
      v = (longint'(s) * longint'(k)) >>> 10;
      if (v > 32767)
         v = 32767;
      if (v < -32768)
         v = -32768;
      if (v >= 0)
         r = (v + 128) / 256;
      else
         r = -((-v + 128) / 256);
      if (r > 127)
         r = 127;
      if (r < -128)
         r = -128;
      return 8'(r);
   endfunction

   task automatic build_expected(output logic converted);
      logic [31:0]       hdr;
      logic [31:0]       trl;
      logic signed [7:0] i8;
      logic signed [7:0] q8;
      int                hl;
      int                n;
      int                w;
      hdr = in_img[0].data;
      for (int i = 0; i < 64; i++)
         exp_img[i] = in_img[i];
      converted = (hdr[31:29] == 3'b000) && model_cfg.convert;
      if (!converted)
         exp_img[0] = '{flag: vita_conv_pkg::FLAG_HEADER, data: {hdr[31:16], 16'(in_len)}};
      else
      begin
         hl = header_words(hdr);
         n  = in_len - hl - int'(hdr[26]);
         for (int k = 0; k < n; k++)
         begin
            i8 = convert_component(in_img[hl + k].data[31:16], model_cfg.scale);
            q8 = convert_component(in_img[hl + k].data[15:0], model_cfg.scale);
            w  = hl + k / 2;
            if (k % 2 == 0)
               exp_img[w] = '{flag: vita_conv_pkg::FLAG_DATA, data: {16'h0000, i8, q8}};
            else
               exp_img[w].data[31:16] = {i8, q8};
         end
         trl = 32'd1 << `VC_TRL_CONV_BIT;
         if (n % 2 == 1)
            trl[`VC_TRL_ODD_BIT] = 1'b1;
         if (hdr[26])
            trl = trl | in_img[in_len - 1].data;
         w = hl + (n + 1) / 2;
         exp_img[w] = '{flag: vita_conv_pkg::FLAG_TRAILER, data: trl};
         hdr[26]    = 1'b1;
         hdr[15:0]  = 16'(w + 1);
         exp_img[0] = '{flag: vita_conv_pkg::FLAG_HEADER, data: hdr};
      end
   endtask

   // hdr_top gives header bits 31:20; a set bit 26 appends a trailer
   task automatic build_packet(input logic [11:0] hdr_top, input int n_smp);
      logic [31:0] hdr;
      int          hl;
      hdr        = rand_bits(32);
      hdr[31:20] = hdr_top;
      hl         = header_words(hdr);
      in_img[0]  = '{flag: vita_conv_pkg::FLAG_HEADER, data: hdr};
      for (int i = 1; i < hl; i++)
         in_img[i] = '{flag: vita_conv_pkg::FLAG_HEADER, data: rand_bits(32)};
      for (int k = 0; k < n_smp; k++)
         in_img[hl + k] = '{flag: vita_conv_pkg::FLAG_DATA, data: rand_bits(32)};
      in_len = hl + n_smp;
      if (hdr[26])
      begin
         in_img[in_len] = '{flag: vita_conv_pkg::FLAG_TRAILER, data: rand_bits(32)};
         in_len++;
      end
   endtask

   task automatic set_sample(input int idx, input int i, input int q);
      in_img[idx].data = {16'(i), 16'(q)};
   endtask

   task automatic write_cfg(input logic [7:0] addr, input logic en,
                            input logic signed [17:0] scale);
      vita_conv_pkg::conv_cfg_t c;
      c = '{convert: en, scale: scale};
      @(negedge clk);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = {13'd0, c};
      @(negedge clk);
      set_stb_i = 1'b0;
      if (addr == `VC_CFG_ADDR)
         model_cfg = c;
   endtask

   task automatic load_packet();
      for (int i = 0; i < in_len; i++)
      begin
         @(negedge clk);
         host_en_i  = 1'b1;
         host_we_i  = 1'b1;
         host_adr_i = `VC_ADDR_W'(i);
         host_dat_i = in_img[i];
      end
      @(negedge clk);
      host_en_i = 1'b0;
      host_we_i = 1'b0;
   endtask

   task automatic read_check(input string name);
      for (int i = 0; i < in_len; i++)
      begin
         @(negedge clk);
         host_en_i  = 1'b1;
         host_we_i  = 1'b0;
         host_adr_i = `VC_ADDR_W'(i);
         @(negedge clk);
         host_en_i = 1'b0;
         check_word(host_dat_o, exp_img[i], $sformatf("%s word %0d", name, i));
      end
   endtask

   task automatic run_packet(input string name);
      logic converted;
      build_expected(converted);
      load_packet();
      @(negedge clk);
      start_i   = 1'b1;
      pkt_len_i = `VC_ADDR_W'(in_len);
      @(negedge clk);
      start_i = 1'b0;
      check_done(1'b0, name);
      if (!converted)
      begin
         // header read, parse, header write, then done on the 4th cycle
         for (int c = 2; c <= 5; c++)
         begin
            @(negedge clk);
            check_done(c == 4, $sformatf("%s cycle %0d", name, c));
         end
      end
      else
      begin
         while (done_o !== 1'b1)
            @(negedge clk);
         @(negedge clk);
         check_done(1'b0, {name, " after done"});
      end
      read_check(name);
   endtask

   task automatic unconverted_packets();
      write_cfg(`VC_CFG_ADDR, 1'b1, 18'sd1024);
      build_packet(12'h200, 5);
      run_packet("non-data packet");
      write_cfg(`VC_CFG_ADDR, 1'b0, 18'sd1024);
      build_packet(12'h040, 4);
      run_packet("conversion off");
   endtask

   task automatic even_count_packet();
      write_cfg(`VC_CFG_ADDR, 1'b1, 18'sd3000);
      build_packet(12'h000, 8);
      run_packet("even count");
   endtask

   task automatic odd_count_with_trailer();
      write_cfg(`VC_CFG_ADDR, 1'b1, 18'sd700);
      build_packet(12'h040, 7);
      run_packet("odd count");
   endtask

   task automatic long_header_packet();
      // stream id, class id, seconds, ticks and trailer: 7 header words
      write_cfg(`VC_CFG_ADDR, 1'b1, -18'sd1100);
      build_packet(12'h1c6, 5);
      run_packet("long header");
   endtask

   task automatic extreme_values();
      // unity scale puts the ties on exact halves
      write_cfg(`VC_CFG_ADDR, 1'b1, 18'sd1024);
      build_packet(12'h000, 8);
      set_sample(1, 128, -128);
      set_sample(2, 384, -384);
      set_sample(3, 32767, -32768);
      set_sample(4, 127, -127);
      set_sample(5, 129, -129);
      set_sample(6, 0, 255);
      set_sample(7, -256, 640);
      set_sample(8, -640, 1);
      run_packet("ties");
      // full-scale negative factor
      write_cfg(`VC_CFG_ADDR, 1'b1, 18'h20000);
      build_packet(12'h000, 4);
      set_sample(1, -32768, 32767);
      set_sample(2, 1, -1);
      set_sample(3, 16384, -16384);
      set_sample(4, 0, 32);
      run_packet("negative full scale");
      write_cfg(`VC_CFG_ADDR, 1'b1, 18'sd131071);
      build_packet(12'h000, 3);
      set_sample(1, 32767, -1);
      set_sample(2, -32768, 0);
      set_sample(3, 1, 2);
      run_packet("positive full scale");
   endtask

   task automatic foreign_cfg_write();
      write_cfg(`VC_CFG_ADDR, 1'b1, -18'sd2500);
      write_cfg(8'h3c, 1'b0, 18'sd1);
      build_packet(12'h000, 6);
      run_packet("other config address");
   endtask

   initial
   begin
      lfsr       = 32'heed200e1;
      model_cfg  = '0;
      arst_n_i   = 1'b0;
      set_stb_i  = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      start_i    = 1'b0;
      pkt_len_i  = '0;
      host_en_i  = 1'b0;
      host_we_i  = 1'b0;
      host_adr_i = '0;
      host_dat_i = '0;
      repeat (8)
         @(posedge clk);
      @(negedge clk);
      arst_n_i = 1'b1;
      check_done(1'b0, "after reset");
      unconverted_packets();
      even_count_packet();
      odd_count_with_trailer();
      long_header_packet();
      extreme_values();
      foreign_cfg_write();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* src/conv_engine.sv */
/*
 conversion engine: config register, header parser, control FSM
 one packet at a time; start_i only while idle
 pack_wr_i takes the buffer port, the sample read waits a cycle
 a converted packet needs at least one payload sample
*/
`timescale 1ns/1ps
`include "vita_conv_consts.svh"

module conv_engine (
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic                      set_stb_i,
   input  logic [7:0]                set_addr_i,
   input  logic [31:0]               set_data_i,
   input  logic                      start_i,
   input  logic [`VC_ADDR_W-1:0]     pkt_len_i,
   output logic                      done_o,
   output logic [`VC_ADDR_W-1:0]     adr_o,
   output logic                      we_o,
   output vita_conv_pkg::buf_word_t  wdat_o,
   input  vita_conv_pkg::buf_word_t  rdat_i,
   output logic signed [17:0]        scale_o,
   output logic signed [15:0]        sample_i_o,
   output logic signed [15:0]        sample_q_o,
   output logic                      stb_mult_o,
   output logic                      stb_clip_o,
   output logic                      stb_round_o,
   output logic                      stb_out_o,
   output vita_conv_pkg::lane_tag_t  tag_o,
   input  logic                      pack_wr_i,
   input  logic [`VC_WORD_W-1:0]     pack_word_i
);

   vita_conv_pkg::conv_cfg_t   cfg;
   vita_conv_pkg::eng_state_e  state;
   vita_conv_pkg::lane_tag_t   tag_pipe [`VC_PIPE_STAGES];

   logic [`VC_ADDR_W-1:0]      read_adr;
   logic [`VC_ADDR_W-1:0]      write_adr;
   logic [`VC_ADDR_W-1:0]      len_q;
   logic [`VC_PIPE_STAGES-1:0] vld;
   logic [31:0]                hd;
   logic [31:0]                new_header;
   logic [31:0]                new_trailer;
   logic [31:0]                trl_mask;
   logic [3:0]                 hdr_len;
   logic                       even;
   logic                       trl_wait;
   logic                       has_trl_q;
   logic                       convert_pkt;
   logic                       issue_rd;
   logic                       rd_last;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         cfg <= '0;
      else if (set_stb_i && (set_addr_i == `VC_CFG_ADDR))
         cfg <= set_data_i[18:0];
   end

   // VITA header decode, valid while the header sits on rdat_i
   assign hd          = rdat_i.data;
   assign hdr_len     = 4'd1 + {3'd0, hd[28]} + {2'd0, hd[27], 1'b0}
                        + {3'd0, |hd[23:22]} + {2'd0, |hd[21:20], 1'b0};
   assign convert_pkt = (hd[31:29] == 3'b000) && cfg.convert;

   // last payload word sits just before the trailer, if any
   assign rd_last  = (read_adr + `VC_ADDR_W'(has_trl_q) + 1'b1) == len_q;
   assign issue_rd = (state == vita_conv_pkg::CONVERT) && !pack_wr_i;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state     <= vita_conv_pkg::IDLE;
         read_adr  <= '0;
         write_adr <= '0;
         even      <= 1'b0;
         trl_wait  <= 1'b0;
         done_o    <= 1'b0;
      end
      else
      begin
         done_o <= (state == vita_conv_pkg::DONE);
         case (state)
            vita_conv_pkg::IDLE:
            begin
               read_adr  <= '0;
               write_adr <= '0;
               even      <= 1'b0;
               if (start_i)
                  state <= vita_conv_pkg::PARSE_HEADER;
            end
            vita_conv_pkg::PARSE_HEADER:
            begin
               if (convert_pkt)
               begin
                  read_adr  <= `VC_ADDR_W'(hdr_len);
                  write_adr <= `VC_ADDR_W'(hdr_len);
                  state     <= vita_conv_pkg::CONVERT;
               end
               else
                  state <= vita_conv_pkg::WRITE_HEADER;
            end
            vita_conv_pkg::CONVERT:
            begin
               if (pack_wr_i)
                  write_adr <= write_adr + 1'b1;
               else
               begin
                  read_adr <= read_adr + 1'b1;
                  even     <= ~even;
                  if (rd_last)
                     state <= vita_conv_pkg::DRAIN;
               end
            end
            vita_conv_pkg::DRAIN:
            begin
               if (pack_wr_i)
               begin
                  write_adr <= write_adr + 1'b1;
                  if (tag_o.last)
                  begin
                     trl_wait <= 1'b0;
                     state    <= has_trl_q ? vita_conv_pkg::READ_TRAILER
                                           : vita_conv_pkg::WRITE_TRAILER;
                  end
               end
            end
            vita_conv_pkg::READ_TRAILER:
            begin
               // read_adr already points at the old trailer
               trl_wait <= 1'b1;
               if (trl_wait)
                  state <= vita_conv_pkg::WRITE_TRAILER;
            end
            vita_conv_pkg::WRITE_TRAILER:
            begin
               write_adr <= '0;
               state     <= vita_conv_pkg::WRITE_HEADER;
            end
            vita_conv_pkg::WRITE_HEADER:
               state <= vita_conv_pkg::DONE;
            default:
               state <= vita_conv_pkg::IDLE;
         endcase
      end
   end

   // packet length, header and trailer words under construction
   always_ff @(posedge clk)
   begin
      case (state)
         vita_conv_pkg::IDLE:
            if (start_i)
               len_q <= pkt_len_i;
         vita_conv_pkg::PARSE_HEADER:
         begin
            has_trl_q  <= hd[`VC_HDR_TRL_BIT];
            new_header <= {hd[31:16], 16'(len_q)};
            if (convert_pkt)
               new_header[`VC_HDR_TRL_BIT] <= 1'b1;
         end
         vita_conv_pkg::CONVERT:
         begin
            if (issue_rd && rd_last)
            begin
               trl_mask                   <= '0;
               trl_mask[`VC_TRL_CONV_BIT] <= 1'b1;
               trl_mask[`VC_TRL_ODD_BIT]  <= ~even;
            end
         end
         vita_conv_pkg::DRAIN:
            if (pack_wr_i && tag_o.last)
               new_trailer <= trl_mask;
         vita_conv_pkg::READ_TRAILER:
            new_trailer <= hd | trl_mask;
         vita_conv_pkg::WRITE_TRAILER:
            new_header[15:0] <= 16'(write_adr) + 16'd1;
         default:
         begin
         end
      endcase
   end

   // valid and tag travel alongside each sample
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         vld <= '0;
      else
         vld <= {vld[`VC_PIPE_STAGES-2:0], issue_rd};
   end

   always_ff @(posedge clk)
   begin
      tag_pipe[0] <= '{last: rd_last, even: even};
      for (int i = 1; i < `VC_PIPE_STAGES; i++)
         tag_pipe[i] <= tag_pipe[i-1];
   end

   assign stb_mult_o  = vld[0];
   assign stb_clip_o  = vld[1];
   assign stb_round_o = vld[2];
   assign stb_out_o   = vld[`VC_PIPE_STAGES-1];
   assign tag_o       = tag_pipe[`VC_PIPE_STAGES-1];
   assign scale_o     = cfg.scale;
   assign sample_i_o  = hd[31:16];
   assign sample_q_o  = hd[15:0];

   assign we_o  = pack_wr_i || (state == vita_conv_pkg::WRITE_HEADER)
                  || (state == vita_conv_pkg::WRITE_TRAILER);
   assign adr_o = we_o ? write_adr : read_adr;

   always_comb
   begin
      case (state)
         vita_conv_pkg::WRITE_HEADER:
            wdat_o = '{flag: vita_conv_pkg::FLAG_HEADER, data: new_header};
         vita_conv_pkg::WRITE_TRAILER:
            wdat_o = '{flag: vita_conv_pkg::FLAG_TRAILER, data: new_trailer};
         default:
            wdat_o = '{flag: vita_conv_pkg::FLAG_DATA, data: pack_word_i};
      endcase
   end

   a_start_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
      start_i |-> (state == vita_conv_pkg::IDLE));

   // in-place rewrite must stay behind the samples still to be read
   a_wr_behind_rd: assert property (@(posedge clk) disable iff (!arst_n_i)
      pack_wr_i |-> (write_adr < read_adr));

endmodule

/* src/packet_buffer.sv */
/*
 two-port packet RAM, registered outputs, one cycle read latency
 the engine port reads every cycle; the host port only when enabled
 both ports must not write one address in the same cycle
*/
`timescale 1ns/1ps
`include "vita_conv_consts.svh"

module packet_buffer (
   input  logic                      clk,
   input  logic                      host_en_i,
   input  logic                      host_we_i,
   input  logic [`VC_ADDR_W-1:0]     host_adr_i,
   input  vita_conv_pkg::buf_word_t  host_dat_i,
   output vita_conv_pkg::buf_word_t  host_dat_o,
   input  logic [`VC_ADDR_W-1:0]     eng_adr_i,
   input  logic                      eng_we_i,
   input  vita_conv_pkg::buf_word_t  eng_dat_i,
   output vita_conv_pkg::buf_word_t  eng_dat_o
);

   vita_conv_pkg::buf_word_t mem [`VC_DEPTH];

   // read-first on both ports
   always_ff @(posedge clk)
   begin
      if (host_en_i)
      begin
         if (host_we_i)
            mem[host_adr_i] <= host_dat_i;
         host_dat_o <= mem[host_adr_i];
      end
      if (eng_we_i)
         mem[eng_adr_i] <= eng_dat_i;
      eng_dat_o <= mem[eng_adr_i];
   end

   // host must stay off the engine's write target
   a_no_wr_clash: assert property (@(posedge clk)
      (host_en_i && host_we_i && eng_we_i) |-> (host_adr_i != eng_adr_i));

endmodule

/* src/sample_packer.sv */
/*
 packs two 8-bit I/Q samples per payload word
 earlier sample goes to the low half; an unpaired last sample
 leaves the upper half zero
*/
`timescale 1ns/1ps
`include "vita_conv_consts.svh"

module sample_packer (
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic                      stb_i,
   input  vita_conv_pkg::lane_tag_t  tag_i,
   input  logic signed [7:0]         i8_i,
   input  logic signed [7:0]         q8_i,
   output logic                      wr_o,
   output logic [`VC_WORD_W-1:0]     word_o
);

   logic [15:0] held;

   // keep the first sample of each pair
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         held <= '0;
      else if (stb_i && !tag_i.even)
         held <= {i8_i, q8_i};
   end

   assign wr_o = stb_i && (tag_i.even || tag_i.last);

   always_comb
   begin
      if (tag_i.last && !tag_i.even)
         word_o = {16'd0, i8_i, q8_i};
      else
         word_o = {i8_i, q8_i, held};
   end

endmodule

/* src/scale_lane.sv */
/*
 one sample component: scale by an 18-bit factor, clip to 16 bits,
 round to 8 bits (nearest, ties away from zero)
 each stage register loads only on its own strobe
*/
`timescale 1ns/1ps

module scale_lane (
   input  logic               clk,
   input  logic               arst_n_i,
   input  logic signed [15:0] sample_i,
   input  logic signed [17:0] scale_i,
   input  logic               stb_mult_i,
   input  logic               stb_clip_i,
   input  logic               stb_round_i,
   output logic signed [7:0]  result_o
);

   logic signed [33:0] prod;
   logic signed [15:0] sat16;
   logic signed [15:0] sat16_nxt;
   logic signed [16:0] rnd_sum;
   logic signed [7:0]  rnd8_nxt;

   always_comb
   begin
      // prod >>> 10 fits 16 bits when bits 33:25 agree
      if (prod[33:25] == {9{prod[33]}})
         sat16_nxt = prod[25:10];
      else
         sat16_nxt = prod[33] ? 16'sh8000 : 16'sh7fff;

      // bias of one less on negatives pushes ties away from zero
      rnd_sum  = {sat16[15], sat16} + (sat16[15] ? 17'sd127 : 17'sd128);
      rnd8_nxt = (rnd_sum[16:15] == 2'b01) ? 8'sd127 : rnd_sum[15:8];
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         prod     <= '0;
         sat16    <= '0;
         result_o <= '0;
      end
      else
      begin
         if (stb_mult_i)
            prod <= sample_i * scale_i;
         if (stb_clip_i)
            sat16 <= sat16_nxt;
         if (stb_round_i)
            result_o <= rnd8_nxt;
      end
   end

endmodule

/* src/vita_conv_consts.svh */
/*
 shared sizes and bit positions for the packet converter
 buffer depth follows the address width; one packet must fit in the buffer
 trailer bits follow the VITA-49 trailer layout
*/
`ifndef VITA_CONV_CONSTS_SVH
`define VITA_CONV_CONSTS_SVH

`define VC_ADDR_W       9
`define VC_DEPTH        (1 << `VC_ADDR_W)
`define VC_WORD_W       32
`define VC_CFG_ADDR     8'h00

// header bit that announces a trailer word
`define VC_HDR_TRL_BIT  26

// trailer marks set by conversion
`define VC_TRL_CONV_BIT 22
`define VC_TRL_ODD_BIT  10

// read, multiply, clip, round
`define VC_PIPE_STAGES  4

`endif

/* src/vita_conv_pkg.sv */
/*
 types shared by the converter RTL and its testbench
 configuration layout matches set_data_i[18:0]
*/
`include "vita_conv_consts.svh"

package vita_conv_pkg;

   // kind of word held in the upper 4 bits of a buffer word
   typedef enum logic [3:0] {
      FLAG_DATA    = 4'd0,
      FLAG_HEADER  = 4'd1,
      FLAG_TRAILER = 4'd2
   } word_flag_e;

   typedef struct packed {
      word_flag_e             flag;
      logic [`VC_WORD_W-1:0]  data;
   } buf_word_t;

   typedef struct packed {
      logic                convert;
      logic signed [17:0]  scale;
   } conv_cfg_t;

   typedef enum logic [2:0] {
      IDLE,
      PARSE_HEADER,
      CONVERT,
      DRAIN,
      READ_TRAILER,
      WRITE_TRAILER,
      WRITE_HEADER,
      DONE
   } eng_state_e;

   // even marks the second sample of a pair
   typedef struct packed {
      logic last;
      logic even;
   } lane_tag_t;

endpackage

/* src/vita_conv_top.sv */
/*
 16-to-8 bit VITA packet converter, in place in its own buffer
 host loads the packet, writes the config, pulses start_i with the length
 and may read back after done_o; hands off the buffer meanwhile
*/
`timescale 1ns/1ps
`include "vita_conv_consts.svh"

module vita_conv_top (
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic                      set_stb_i,
   input  logic [7:0]                set_addr_i,
   input  logic [31:0]               set_data_i,
   input  logic                      start_i,
   input  logic [`VC_ADDR_W-1:0]     pkt_len_i,
   output logic                      done_o,
   input  logic                      host_en_i,
   input  logic                      host_we_i,
   input  logic [`VC_ADDR_W-1:0]     host_adr_i,
   input  vita_conv_pkg::buf_word_t  host_dat_i,
   output vita_conv_pkg::buf_word_t  host_dat_o
);

   vita_conv_pkg::buf_word_t  eng_wdat;
   vita_conv_pkg::buf_word_t  eng_rdat;
   vita_conv_pkg::lane_tag_t  tag;
   logic [`VC_ADDR_W-1:0]     eng_adr;
   logic                      eng_we;
   logic signed [17:0]        scale;
   logic signed [15:0]        lane_smp [2];
   logic signed [7:0]         lane_res [2];
   logic                      stb_mult;
   logic                      stb_clip;
   logic                      stb_round;
   logic                      stb_out;
   logic                      pack_wr;
   logic [`VC_WORD_W-1:0]     pack_word;

   packet_buffer u_buf (
      .clk        (clk),
      .host_en_i  (host_en_i),
      .host_we_i  (host_we_i),
      .host_adr_i (host_adr_i),
      .host_dat_i (host_dat_i),
      .host_dat_o (host_dat_o),
      .eng_adr_i  (eng_adr),
      .eng_we_i   (eng_we),
      .eng_dat_i  (eng_wdat),
      .eng_dat_o  (eng_rdat)
   );

   conv_engine u_eng (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .start_i     (start_i),
      .pkt_len_i   (pkt_len_i),
      .done_o      (done_o),
      .adr_o       (eng_adr),
      .we_o        (eng_we),
      .wdat_o      (eng_wdat),
      .rdat_i      (eng_rdat),
      .scale_o     (scale),
      .sample_i_o  (lane_smp[0]),
      .sample_q_o  (lane_smp[1]),
      .stb_mult_o  (stb_mult),
      .stb_clip_o  (stb_clip),
      .stb_round_o (stb_round),
      .stb_out_o   (stb_out),
      .tag_o       (tag),
      .pack_wr_i   (pack_wr),
      .pack_word_i (pack_word)
   );

   // lane 0 carries I, lane 1 carries Q
   for (genvar g = 0; g < 2; g++)
   begin : g_lane
      scale_lane u_lane (
         .clk         (clk),
         .arst_n_i    (arst_n_i),
         .sample_i    (lane_smp[g]),
         .scale_i     (scale),
         .stb_mult_i  (stb_mult),
         .stb_clip_i  (stb_clip),
         .stb_round_i (stb_round),
         .result_o    (lane_res[g])
      );
   end

   sample_packer u_pack (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .stb_i    (stb_out),
      .tag_i    (tag),
      .i8_i     (lane_res[0]),
      .q8_i     (lane_res[1]),
      .wr_o     (pack_wr),
      .word_o   (pack_word)
   );

endmodule

/* vita_conv_top.f */
+incdir+src
src/vita_conv_pkg.sv
src/packet_buffer.sv
src/conv_engine.sv
src/scale_lane.sv
src/sample_packer.sv
src/vita_conv_top.sv
bench/vita_conv_tb.sv
